// ==== all.f ====
verilog/spram_pkg.sv
verilog/mem_word_if.sv
verilog/spram_bank.sv
verilog/spram_word.sv
verilog/byte_port.sv
verilog/port_arbiter.sv
verilog/spram_sub_top.sv
tests/spram_props.sv
tests/spram_tb.sv

// ==== Makefile ====
# Verilator build and run of the spram subsystem testbench

VERILATOR ?= verilator
TOP       ?= spram_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Simulation failed
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation, search the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; else echo "PASS"; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/spram_tb.sv ====
// testbench for the single-port memory subsystem
// random word and byte traffic checked against a shadow memory by assertions

`timescale 1ns/1ps

module spram_tb
    import spram_pkg::*;
();
    localparam int bank_aw = 8;                 // small array so addresses get reused
    localparam int nwords  = 1 << (bank_aw + 1);

    logic                clk;
    logic                rst_n;
    logic                w_req;
    logic                w_we;
    logic [LANES-1:0]    w_bmsk;
    logic [bank_aw:0]    w_addr;
    logic [WORD_W-1:0]   w_wdata;
    logic [WORD_W-1:0]   w_rdata;
    logic                w_rvalid;
    logic                b_req;
    logic                b_we;
    logic [bank_aw+2:0]  b_addr;
    logic [7:0]          b_wdata;
    logic [7:0]          b_rdata;
    logic                b_rvalid;

    logic [WORD_W-1:0]   shadow [0:nwords-1];
    logic [WORD_W-1:0]   w_expq [$];            // expected word read data, issue order
    logic [7:0]          b_expq [$];
    logic [WORD_W-1:0]   w_head;
    logic [7:0]          b_head;
    int                  w_pend;
    int                  b_pend;
    logic                w_ret;                 // word read valid seen this cycle
    logic                b_ret;
    logic [15:0]         lfsr;
    logic                quiet;                 // no read outstanding yet
    logic [bank_aw:0]    waddr [8];
    int                  err_cnt;
    int                  pass_cnt;
    int                  test_cnt;

    spram_sub_top #(.bank_aw(bank_aw)) DUT (.*);

    always #10 clk = ~clk;

    w_data_chk: assert property (@(posedge clk) disable iff (!rst_n) w_rvalid |-> w_rdata == w_head)
        else begin
            $display("Error at %0t: w_rdata expected %h got %h", $time,
                     $sampled(w_head), $sampled(w_rdata));
            err_cnt++;
        end

    b_data_chk: assert property (@(posedge clk) disable iff (!rst_n) b_rvalid |-> b_rdata == b_head)
        else begin
            $display("Error at %0t: b_rdata expected %h got %h", $time,
                     $sampled(b_head), $sampled(b_rdata));
            err_cnt++;
        end

    extra_chk: assert property (@(posedge clk) disable iff (!rst_n)
        !(w_rvalid && w_pend == 0) && !(b_rvalid && b_pend == 0))
        else begin
            $display("read valid came back at %0t with no read outstanding", $time);
            err_cnt++;
        end

    quiet_chk: assert property (@(posedge clk) quiet |-> !w_rvalid && !b_rvalid)
        else begin
            $display("read valid raised at %0t before any read was issued", $time);
            err_cnt++;
        end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);   // one step per bit
        end
        return v;
    endfunction

    task automatic refresh_heads();
        w_pend = w_expq.size();
        b_pend = b_expq.size();
        w_head = (w_pend != 0) ? w_expq[0] : '0;
        b_head = (b_pend != 0) ? b_expq[0] : '0;
    endtask

    // retire expectations the cycle after their read valid has been checked
    always @(negedge clk) begin
        if (w_ret && w_expq.size() != 0) begin
            void'(w_expq.pop_front());
        end
        if (b_ret && b_expq.size() != 0) begin
            void'(b_expq.pop_front());
        end
        w_ret = w_rvalid;                       // checked at the coming rising edge
        b_ret = b_rvalid;
        refresh_heads();
    end

    task automatic word_model(input logic we, input logic [3:0] m,
                              input logic [bank_aw:0] a, input logic [31:0] d);
        if (we) begin
            for (int l = 0; l < LANES; l++) begin
                if (m[l]) begin
                    shadow[a][l*8 +: 8] = d[l*8 +: 8];
                end
            end
        end else begin
            w_expq.push_back(shadow[a]);
        end
        refresh_heads();
    endtask

    // byte A lives in lane A mod 4 of word A div 4
    task automatic byte_model(input logic we, input logic [bank_aw+2:0] a, input logic [7:0] d);
        if (we) begin
            shadow[a[bank_aw+2:2]][a[1:0]*8 +: 8] = d;
        end else begin
            b_expq.push_back(shadow[a[bank_aw+2:2]][a[1:0]*8 +: 8]);
        end
        refresh_heads();
    endtask

    task automatic word_op(input logic we, input logic [3:0] m,
                           input logic [bank_aw:0] a, input logic [31:0] d);
        {w_req, w_we, w_bmsk, w_addr, w_wdata} = {1'b1, we, m, a, d};
        word_model(we, m, a, d);
        @(negedge clk);
        w_req = 1'b0;
    endtask

    task automatic byte_op(input logic we, input logic [bank_aw+2:0] a, input logic [7:0] d);
        {b_req, b_we, b_addr, b_wdata} = {1'b1, we, a, d};
        byte_model(we, a, d);
        @(negedge clk);
        b_req = 1'b0;
    endtask

    // both strobes together, then a free cycle for the held byte request
    task automatic both_op(input logic wwe, input logic [3:0] m, input logic [bank_aw:0] wa,
                           input logic [31:0] wd, input logic bwe,
                           input logic [bank_aw+2:0] ba, input logic [7:0] bd);
        {w_req, w_we, w_bmsk, w_addr, w_wdata} = {1'b1, wwe, m, wa, wd};
        {b_req, b_we, b_addr, b_wdata} = {1'b1, bwe, ba, bd};
        word_model(wwe, m, wa, wd);
        byte_model(bwe, ba, bd);
        @(negedge clk);
        w_req = 1'b0;
        b_req = 1'b0;
        @(negedge clk);
    endtask

    task automatic drain();
        int n;
        n = 0;
        while ((w_pend != 0 || b_pend != 0) && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (w_pend != 0 || b_pend != 0) begin
            $display("timeout at %0t waiting for %0d word and %0d byte reads to return",
                     $time, w_pend, b_pend);
            err_cnt++;
            w_expq.delete();
            b_expq.delete();
            refresh_heads();
        end
    endtask

    task automatic report_test(input string name, input int e0);
        test_cnt++;
        if (err_cnt == e0) begin
            pass_cnt++;
            $display("test %0d %s: passed", test_cnt, name);
        end else begin
            $display("test %0d %s: FAILED with %0d errors", test_cnt, name, err_cnt - e0);
        end
    endtask

    initial begin
        int               e0;
        logic [31:0]      r;
        logic [bank_aw-1:0] low;
        clk = 1'b0;
        rst_n = 1'b1;
        quiet = 1'b1;
        w_ret = 1'b0;
        b_ret = 1'b0;
        lfsr = 16'd29457;
        {err_cnt, pass_cnt, test_cnt} = '0;
        {w_req, w_we, w_bmsk, w_addr, w_wdata} = '0;
        {b_req, b_we, b_addr, b_wdata} = '0;
        refresh_heads();
        #1 rst_n = 1'b0;                        // clean falling edge on the async reset
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(negedge clk);
        quiet = 1'b0;
        report_test("reset quiet", 0);

        e0 = err_cnt;
        for (int i = 0; i < 8; i++) begin
            waddr[i] = (bank_aw+1)'(rand_bits(bank_aw + 1));
            word_op(1'b1, 4'hF, waddr[i], rand_bits(32));
        end
        for (int i = 0; i < 8; i++) begin
            word_op(1'b0, 4'h0, waddr[i], '0);
        end
        drain();
        report_test("full word write and read", e0);

        e0 = err_cnt;
        for (int i = 0; i < 8; i++) begin
            word_op(1'b1, 4'(rand_bits(4)), waddr[i], rand_bits(32));
            word_op(1'b0, 4'h0, waddr[i], '0);
        end
        drain();
        report_test("partial byte mask", e0);

        e0 = err_cnt;
        for (int i = 0; i < 4; i++) begin
            low = waddr[i][bank_aw-1:0];
            word_op(1'b1, 4'hF, {1'b0, low}, rand_bits(32));
            word_op(1'b1, 4'hF, {1'b1, low}, rand_bits(32));
            word_op(1'b0, 4'h0, {1'b0, low}, '0);
            word_op(1'b1, 4'hF, {1'b0, low}, rand_bits(32));
            word_op(1'b0, 4'h0, {1'b1, low}, '0);
        end
        drain();
        report_test("bank pair independence", e0);

        e0 = err_cnt;
        for (int i = 0; i < 8; i++) begin
            byte_op(1'b1, {waddr[i], 2'(rand_bits(2))}, 8'(rand_bits(8)));
            word_op(1'b0, 4'h0, waddr[i], '0);
        end
        for (int i = 0; i < 8; i++) begin
            word_op(1'b1, 4'hF, waddr[i], rand_bits(32));
            byte_op(1'b0, {waddr[i], 2'(rand_bits(2))}, 8'h00);
        end
        drain();
        report_test("byte and word lanes", e0);

        e0 = err_cnt;
        for (int i = 0; i < 12; i++) begin
            r = rand_bits(22);
            both_op(r[0], r[5:2], waddr[r[8:6]], rand_bits(32),
                    r[1], {waddr[r[11:9]], r[13:12]}, r[21:14]);
        end
        drain();
        report_test("same cycle collision", e0);

        $display("%0d of %0d tests passed, %0d errors", pass_cnt, test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : spram_tb

// ==== tests/spram_props.sv ====
// protocol checks bound onto the memory subsystem top
// read latencies, spacing after a collision, quiet outputs in reset

`timescale 1ns/1ps

module spram_props (
    input logic clk,
    input logic rst_n,
    input logic w_req,
    input logic w_we,
    input logic w_rvalid,
    input logic b_req,
    input logic b_we,
    input logic b_rvalid
);
    // word reads answer exactly one cycle later, never otherwise
    word_latency: assert property (@(posedge clk) disable iff (!rst_n)
        w_rvalid == $past(w_req && !w_we))
        else $error("w_rvalid did not follow a word read by exactly one cycle");

    byte_direct: assert property (@(posedge clk) disable iff (!rst_n)
        $past(b_req && !b_we && !w_req) |-> b_rvalid)
        else $error("byte read without collision did not return in one cycle");

    byte_held: assert property (@(posedge clk) disable iff (!rst_n)
        $past(b_req && !b_we && w_req, 2) |-> b_rvalid)
        else $error("byte read held by a collision did not return in two cycles");

    // the hold register has one entry
    collision_gap: assert property (@(posedge clk) disable iff (!rst_n)
        $past(w_req && b_req) |-> !b_req)
        else $error("byte request strobed right after a collision");

    reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !w_rvalid && !b_rvalid)
        else $error("read valid raised while in reset");

endmodule : spram_props

bind spram_sub_top spram_props u_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .w_req    (w_req),
    .w_we     (w_we),
    .w_rvalid (w_rvalid),
    .b_req    (b_req),
    .b_we     (b_we),
    .b_rvalid (b_rvalid)
);

// ==== verilog/spram_sub_top.sv ====
// single-port memory subsystem top
// cpu word port and debug byte port share one banked 32-bit memory

`timescale 1ns/1ps

module spram_sub_top
    import spram_pkg::*;
#(
    parameter int bank_aw = 14
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // word port
    input  logic                  w_req,
    input  logic                  w_we,
    input  logic [LANES-1:0]      w_bmsk,
    input  logic [bank_aw:0]      w_addr,
    input  logic [WORD_W-1:0]     w_wdata,
    output logic [WORD_W-1:0]     w_rdata,
    output logic                  w_rvalid,
    // byte port
    input  logic                  b_req,
    input  logic                  b_we,
    input  logic [bank_aw+2:0]    b_addr,
    input  logic [7:0]            b_wdata,
    output logic [7:0]            b_rdata,
    output logic                  b_rvalid
);
    mem_word_if #(.bank_aw(bank_aw)) byte_bus ();   // byte adapter to arbiter
    mem_word_if #(.bank_aw(bank_aw)) mem_bus ();    // arbiter to banks

    byte_port #(
        .bank_aw (bank_aw)
    ) u_byte_port (
        .clk     (clk),
        .rst_n   (rst_n),
        .b_req   (b_req),
        .b_we    (b_we),
        .b_addr  (b_addr),
        .b_wdata (b_wdata),
        .b_rdata (b_rdata),
        .bus     (byte_bus.master)
    );

    port_arbiter #(
        .bank_aw (bank_aw)
    ) u_arbiter (
        .clk      (clk),
        .rst_n    (rst_n),
        .w_req    (w_req),
        .w_we     (w_we),
        .w_bmsk   (w_bmsk),
        .w_addr   (w_addr),
        .w_wdata  (w_wdata),
        .w_rdata  (w_rdata),
        .w_rvalid (w_rvalid),
        .byte_bus (byte_bus.slave),
        .mem_bus  (mem_bus.master),
        .b_rvalid (b_rvalid)
    );

    spram_word #(
        .bank_aw (bank_aw)
    ) u_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (mem_bus.slave)
    );

endmodule : spram_sub_top

// ==== verilog/port_arbiter.sv ====
// request arbiter for the word and byte ports
// word port has fixed priority, a colliding byte request waits one cycle
// in a hold register; read data is returned to the port that issued it

`timescale 1ns/1ps

module port_arbiter
    import spram_pkg::*;
#(
    parameter int bank_aw = 14
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  w_req,
    input  logic                  w_we,
    input  logic [LANES-1:0]      w_bmsk,
    input  logic [bank_aw:0]      w_addr,
    input  logic [WORD_W-1:0]     w_wdata,
    output logic [WORD_W-1:0]     w_rdata,
    output logic                  w_rvalid,
    mem_word_if.slave             byte_bus,
    mem_word_if.master            mem_bus,
    output logic                  b_rvalid
);
    logic                hold_q;           // byte request waiting
    logic                hold_we;
    logic [LANES-1:0]    hold_bmsk;
    logic [bank_aw:0]    hold_addr;
    logic [WORD_W-1:0]   hold_wdata;
    logic                issue_hold;
    logic                issue_byte;
    logic                hold_load;
    logic                rd_q;             // last issued access was a read
    port_sel_e           sel_q;

    assign issue_hold = hold_q && !w_req;
    assign issue_byte = byte_bus.req && !w_req && !hold_q;
    assign hold_load  = byte_bus.req && !issue_byte;   // lost to the word port

    always_comb begin
        mem_bus.req = w_req || hold_q || byte_bus.req;
        if (w_req) begin
            mem_bus.we    = w_we;
            mem_bus.bmsk  = w_bmsk;
            mem_bus.addr  = w_addr;
            mem_bus.wdata = w_wdata;
        end else if (hold_q) begin
            mem_bus.we    = hold_we;
            mem_bus.bmsk  = hold_bmsk;
            mem_bus.addr  = hold_addr;
            mem_bus.wdata = hold_wdata;
        end else begin
            mem_bus.we    = byte_bus.we;
            mem_bus.bmsk  = byte_bus.bmsk;
            mem_bus.addr  = byte_bus.addr;
            mem_bus.wdata = byte_bus.wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_q <= 1'b0;
            rd_q   <= 1'b0;
            sel_q  <= PORT_WORD;
        end else begin
            hold_q <= hold_load || (hold_q && !issue_hold);
            rd_q   <= mem_bus.req && !mem_bus.we;
            sel_q  <= w_req ? PORT_WORD : PORT_BYTE;
        end
    end

    // held request payload
    always_ff @(posedge clk) begin
        if (hold_load) begin
            hold_we    <= byte_bus.we;
            hold_bmsk  <= byte_bus.bmsk;
            hold_addr  <= byte_bus.addr;
            hold_wdata <= byte_bus.wdata;
        end
    end

    // read return goes to whichever side owned the access
    assign w_rvalid       = rd_q && (sel_q == PORT_WORD);
    assign b_rvalid       = rd_q && (sel_q == PORT_BYTE);
    assign w_rdata        = (sel_q == PORT_WORD) ? mem_bus.rdata : '0;
    assign byte_bus.rdata = (sel_q == PORT_BYTE) ? mem_bus.rdata : '0;

endmodule : port_arbiter

// ==== verilog/byte_port.sv ====
// byte port adapter for debug access
// replicates the write byte on every lane, enables one lane,
// and picks the read byte with the lane index of the request

`timescale 1ns/1ps

module byte_port
    import spram_pkg::*;
#(
    parameter int bank_aw = 14
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   b_req,
    input  logic                   b_we,
    input  logic [bank_aw+2:0]     b_addr,
    input  logic [7:0]             b_wdata,
    output logic [7:0]             b_rdata,
    mem_word_if.master             bus
);
    localparam int byte_w = WORD_W / LANES;

    lane_t lane;
    lane_t lane_q;                         // lane of the outstanding read

    assign lane = lane_t'(b_addr[1:0]);

    // request path is pure wiring plus lane decode
    assign bus.req   = b_req;
    assign bus.we    = b_we;
    assign bus.addr  = b_addr[bank_aw+2:2];            // drop the lane bits
    assign bus.wdata = {LANES{b_wdata}};               // same byte on all lanes
    assign bus.bmsk  = LANES'(1) << lane;              // one-hot lane enable

    // the arbiter may hold the read a cycle, no new byte req arrives meanwhile
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_q <= '0;
        end else if (b_req && !b_we) begin
            lane_q <= lane;
        end
    end

    assign b_rdata = bus.rdata[lane_q*byte_w +: byte_w];

endmodule : byte_port

// ==== verilog/spram_word.sv ====
// banked 32-bit word memory
// two pairs of halfword banks, the top address bit selects a pair;
// byte enables expand into nibble masks for each half

`timescale 1ns/1ps

module spram_word
    import spram_pkg::*;
#(
    parameter int bank_aw = 14
) (
    input  logic         clk,
    input  logic         rst_n,
    mem_word_if.slave    bus
);
    logic [HALF_W-1:0] rd_half [2][2];    // [pair][half]
    logic [3:0]        nib_msk [2];       // per half, low half = lanes 0/1
    logic [1:0]        pair_cs;
    logic              pair_q;            // pair addressed by last read

    // each byte enable covers two nibbles of its half
    assign nib_msk[0] = {bus.bmsk[1], bus.bmsk[1], bus.bmsk[0], bus.bmsk[0]};
    assign nib_msk[1] = {bus.bmsk[3], bus.bmsk[3], bus.bmsk[2], bus.bmsk[2]};

    for (genvar p = 0; p < 2; p++) begin : g_pair
        assign pair_cs[p] = bus.req && (bus.addr[bank_aw] == 1'(p));

        for (genvar h = 0; h < 2; h++) begin : g_half
            spram_bank #(
                .bank_aw (bank_aw)
            ) u_bank (
                .clk   (clk),
                .cs    (pair_cs[p]),
                .we    (bus.we),
                .mask  (nib_msk[h]),
                .addr  (bus.addr[bank_aw-1:0]),
                .wdata (bus.wdata[h*HALF_W +: HALF_W]),
                .rdata (rd_half[p][h])
            );
        end
    end

    // remember which pair answers, banks hold their output otherwise
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pair_q <= 1'b0;
        end else if (bus.req && !bus.we) begin
            pair_q <= bus.addr[bank_aw];
        end
    end

    assign bus.rdata = {rd_half[pair_q][1], rd_half[pair_q][0]};

endmodule : spram_word

// ==== verilog/spram_bank.sv ====
// behavioural single-port bank, one halfword wide
// nibble write mask, registered read data held while deselected

`timescale 1ns/1ps

module spram_bank
    import spram_pkg::*;
#(
    parameter int bank_aw = 14
) (
    input  logic                 clk,
    input  logic                 cs,
    input  logic                 we,
    input  logic [3:0]           mask,    // one bit per nibble, 1 = write
    input  logic [bank_aw-1:0]   addr,
    input  logic [HALF_W-1:0]    wdata,
    output logic [HALF_W-1:0]    rdata
);
    localparam int nib_n = HALF_W / 4;    // nibbles per halfword
    localparam int depth = 1 << bank_aw;

    logic [HALF_W-1:0] mem [0:depth-1];

    // write lands at the enabled edge, read data shows up after it
    always_ff @(posedge clk) begin
        if (cs) begin
            if (we) begin
                for (int i = 0; i < nib_n; i++) begin
                    if (mask[i]) begin
                        mem[addr][i*4 +: 4] <= wdata[i*4 +: 4];
                    end
                end
            end else begin
                rdata <= mem[addr];       // registered output
            end
        end
    end

endmodule : spram_bank

// ==== verilog/mem_word_if.sv ====
// word bus between the request side and the banked memory
// single-cycle strobe, byte mask, read data valid one cycle after a read

`timescale 1ns/1ps

interface mem_word_if
    import spram_pkg::*;
#(
    parameter int bank_aw = 14
);
    logic                 req;      // one-cycle request strobe
    logic                 we;       // 1 = write, 0 = read
    logic [LANES-1:0]     bmsk;     // byte lanes written
    logic [bank_aw:0]     addr;     // top bit picks the bank pair
    logic [WORD_W-1:0]    wdata;
    logic [WORD_W-1:0]    rdata;    // valid the cycle after a read req

    modport master (output req, we, bmsk, addr, wdata, input rdata);
    modport slave  (input req, we, bmsk, addr, wdata, output rdata);

endinterface : mem_word_if

// ==== verilog/spram_pkg.sv ====
// spram subsystem shared definitions
// widths, byte lane index and port tag used across the banked memory

package spram_pkg;

    // word and bank geometry
    localparam int WORD_W = 32;    // memory word width
    localparam int HALF_W = 16;    // one bank holds half a word
    localparam int LANES  = 4;     // byte lanes per word

    // byte lane inside a word
    typedef logic [1:0] lane_t;

    // owner of an access issued to the banks
    typedef enum logic {
        PORT_WORD = 1'b0,          // cpu word port
        PORT_BYTE = 1'b1           // debug byte port
    } port_sel_e;

endpackage : spram_pkg
